// ==== build.f ====
hdl/core_pkg.sv
hdl/instr_decode.sv
hdl/reg_file.sv
hdl/exec_branch.sv
hdl/exec_alu.sv
hdl/exec_writeback.sv
hdl/exec_stage.sv
tests/exec_stage_checker.sv
tests/exec_stage_tb.sv

// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // Instruction bits 6:2
    typedef enum logic [4:0] {
        OP_LUI    = 5'b01101,
        OP_AUIPC  = 5'b00101,
        OP_JAL    = 5'b11011,
        OP_JALR   = 5'b11001,
        OP_BRANCH = 5'b11000,
        OP_IMM    = 5'b00100,
        OP_REG    = 5'b01100
    } opcode_e;

    // 010 and 011 are reserved
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_funct3_e;

    // Shifts (001, 101) are not supported
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_funct3_e;

endpackage

`default_nettype wire

// ==== hdl/exec_alu.sv ====
`default_nettype none

module exec_alu #(
    parameter int XLEN = 32,
    parameter int ALEN = 32
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire  [ALEN-1:0]         d_addr,
    input  wire  core_pkg::opcode_e opcode,
    input  wire  [2:0]              funct3,
    input  wire                     funct7_5,
    input  wire  [XLEN-1:0]         rs1_data,
    input  wire  [XLEN-1:0]         rs2_data,
    input  wire  [XLEN-1:0]         i_imm,
    input  wire  [XLEN-1:0]         u_imm,
    input  wire                     input_valid,
    input  wire                     input_is_branch,
    output logic                    alu_output_valid,
    output logic                    alu_exception,
    output logic [XLEN-1:0]         alu_result
);

    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] sum_diff;
    logic [XLEN-1:0] result_comb;
    logic            illegal_comb;
    logic            is_reg;
    logic            alu_fire;

    assign alu_fire  = input_valid && !input_is_branch;
    assign is_reg    = opcode == core_pkg::OP_REG;
    assign operand_b = is_reg ? rs2_data : i_imm;
    assign sum_diff  = (is_reg && funct7_5) ? rs1_data - operand_b
                                            : rs1_data + operand_b;

    always_comb begin
        result_comb  = sum_diff;
        illegal_comb = 1'b0;
        case (opcode)
            core_pkg::OP_LUI:   result_comb = u_imm;
            core_pkg::OP_AUIPC: result_comb = XLEN'(d_addr) + u_imm;
            core_pkg::OP_IMM, core_pkg::OP_REG: begin
                // Only SUB may set funct7 bit 5
                illegal_comb = is_reg && funct7_5 && (funct3 != core_pkg::F3_ADD);
                case (core_pkg::alu_funct3_e'(funct3))
                    core_pkg::F3_ADD:  result_comb = sum_diff;
                    core_pkg::F3_SLT:  result_comb = XLEN'($signed(rs1_data) <
                                                           $signed(operand_b));
                    core_pkg::F3_SLTU: result_comb = XLEN'(rs1_data < operand_b);
                    core_pkg::F3_XOR:  result_comb = rs1_data ^ operand_b;
                    core_pkg::F3_OR:   result_comb = rs1_data | operand_b;
                    core_pkg::F3_AND:  result_comb = rs1_data & operand_b;
                    default:           illegal_comb = 1'b1; // Shifts
                endcase
            end
            default: illegal_comb = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_output_valid <= 1'b0;
        end else begin
            alu_output_valid <= alu_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_fire) begin
            alu_exception <= illegal_comb;
            alu_result    <= result_comb;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/exec_branch.sv ====
`default_nettype none

module exec_branch #(
    parameter int XLEN = 32,
    parameter int ALEN = 32
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire  [ALEN-1:0]         d_addr,
    input  wire  [ALEN-1:0]         d_next_addr,
    input  wire  core_pkg::opcode_e opcode,
    input  wire  [2:0]              funct3,
    input  wire  [XLEN-1:0]         rs1_data,
    input  wire  [XLEN-1:0]         rs2_data,
    input  wire  [XLEN-1:0]         i_imm,
    input  wire  [XLEN-1:0]         b_imm,
    input  wire  [XLEN-1:0]         j_imm,
    input  wire                     input_valid_unless_mispredict,
    input  wire                     input_valid,
    input  wire                     input_is_branch,
    output logic                    exec_branch_output_valid,
    output logic                    exec_branch_exception,
    output logic                    exec_branch_taken,
    output logic [XLEN-1:0]         exec_branch_result,
    output logic [ALEN-1:0]         exec_branch_target,
    output logic [ALEN-1:0]         last_branch_target,
    output logic                    exec_mispredict_detected
);

    logic [ALEN-1:0] adder_base;
    logic [ALEN-1:0] adder_offset;
    logic [ALEN-1:0] adder_sum;
    logic [ALEN-1:0] target_comb;
    logic            reserved_funct3;
    logic            cond_taken;
    logic            rs_equal;
    logic            rs_less_u;
    logic            rs_less_s;
    logic            branch_fire;

    assign branch_fire = input_valid && input_is_branch;

    // Single target adder
    always_comb begin
        adder_base      = d_addr;
        adder_offset    = b_imm[ALEN-1:0];
        reserved_funct3 = 1'b0;
        case (opcode)
            core_pkg::OP_JAL: begin
                adder_offset = j_imm[ALEN-1:0];
            end
            core_pkg::OP_JALR: begin
                adder_base      = rs1_data[ALEN-1:0];
                adder_offset    = i_imm[ALEN-1:0];
                reserved_funct3 = funct3 != 3'b000;
            end
            core_pkg::OP_BRANCH: begin
                reserved_funct3 = funct3 == 3'b010 || funct3 == 3'b011;
            end
            default: ;
        endcase
    end

    assign adder_sum   = adder_base + adder_offset;
    assign target_comb = (opcode == core_pkg::OP_JALR) ? {adder_sum[ALEN-1:1], 1'b0}
                                                       : adder_sum;

    assign rs_equal  = rs1_data == rs2_data;
    assign rs_less_u = rs1_data < rs2_data;
    assign rs_less_s = $signed(rs1_data) < $signed(rs2_data);

    always_comb begin
        cond_taken = 1'b1; // Jumps
        if (opcode == core_pkg::OP_BRANCH) begin
            case (core_pkg::branch_funct3_e'(funct3))
                core_pkg::F3_BEQ:  cond_taken = rs_equal;
                core_pkg::F3_BNE:  cond_taken = !rs_equal;
                core_pkg::F3_BLT:  cond_taken = rs_less_s;
                core_pkg::F3_BGE:  cond_taken = !rs_less_s;
                core_pkg::F3_BLTU: cond_taken = rs_less_u;
                core_pkg::F3_BGEU: cond_taken = !rs_less_u;
                default:           cond_taken = 1'b0; // Reserved encodings
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_branch_output_valid <= 1'b0;
        end else begin
            exec_branch_output_valid <= branch_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (branch_fire) begin
            // Word alignment, since there is no C extension
            exec_branch_exception <= reserved_funct3 || (target_comb[1:0] != 2'b00);
            exec_branch_target    <= target_comb;
            exec_branch_result    <= XLEN'(d_next_addr); // Link value
        end
    end

    // Front end predicts fall-through, so check the next valid address
    assign exec_mispredict_detected = input_valid_unless_mispredict && exec_branch_taken &&
                                      (last_branch_target != d_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_branch_taken <= 1'b0;
        end else if (input_valid_unless_mispredict) begin
            exec_branch_taken <= branch_fire && cond_taken; // Held over idle cycles
        end
    end

    always_ff @(posedge clk) begin
        if (branch_fire && cond_taken) begin
            last_branch_target <= target_comb;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/exec_stage.sv ====
`default_nettype none

module exec_stage #(
    parameter int XLEN = 32,
    parameter int ALEN = 32
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              in_valid,
    input  wire  [31:0]      in_instr,
    input  wire  [ALEN-1:0]  in_addr,
    output logic             retire_valid,
    output logic [4:0]       retire_rd,
    output logic [XLEN-1:0]  retire_data,
    output logic             retire_exception,
    output logic             retire_taken,
    output logic             redirect_valid,
    output logic [ALEN-1:0]  redirect_addr
);

    logic              d_valid;
    logic [ALEN-1:0]   d_addr;
    logic [ALEN-1:0]   d_next_addr;
    core_pkg::opcode_e d_opcode;
    logic [4:0]        d_rd;
    logic [2:0]        d_funct3;
    logic              d_funct7_5;
    logic [4:0]        d_rs1;
    logic [4:0]        d_rs2;
    logic [XLEN-1:0]   i_imm;
    logic [XLEN-1:0]   b_imm;
    logic [XLEN-1:0]   j_imm;
    logic [XLEN-1:0]   u_imm;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic              we;
    logic [4:0]        wr_rd;
    logic [XLEN-1:0]   wr_data;
    logic              input_is_branch;
    logic              input_valid;
    logic              exec_mispredict_detected;
    logic              exec_branch_output_valid;
    logic              exec_branch_exception;
    logic              exec_branch_taken;
    logic [XLEN-1:0]   exec_branch_result;
    logic              alu_output_valid;
    logic              alu_exception;
    logic [XLEN-1:0]   alu_result;

    assign input_is_branch = d_opcode == core_pkg::OP_JAL ||
                             d_opcode == core_pkg::OP_JALR ||
                             d_opcode == core_pkg::OP_BRANCH;
    assign input_valid     = d_valid && !exec_mispredict_detected; // Kill wrong path
    assign redirect_valid  = exec_mispredict_detected;

    instr_decode #(.XLEN(XLEN), .ALEN(ALEN)) decode0 (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_instr(in_instr),
        .in_addr(in_addr), .flush(exec_mispredict_detected), .d_valid(d_valid),
        .d_addr(d_addr), .d_next_addr(d_next_addr), .d_opcode(d_opcode), .d_rd(d_rd),
        .d_funct3(d_funct3), .d_funct7_5(d_funct7_5), .d_rs1(d_rs1), .d_rs2(d_rs2),
        .i_imm(i_imm), .b_imm(b_imm), .j_imm(j_imm), .u_imm(u_imm)
    );

    reg_file #(.XLEN(XLEN)) regs0 (
        .clk(clk), .rst(rst), .rs1(d_rs1), .rs2(d_rs2), .we(we), .wr_rd(wr_rd),
        .wr_data(wr_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    exec_branch #(.XLEN(XLEN), .ALEN(ALEN)) branch0 (
        .clk(clk), .rst(rst), .d_addr(d_addr), .d_next_addr(d_next_addr),
        .opcode(d_opcode), .funct3(d_funct3), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .i_imm(i_imm), .b_imm(b_imm), .j_imm(j_imm),
        .input_valid_unless_mispredict(d_valid), .input_valid(input_valid),
        .input_is_branch(input_is_branch),
        .exec_branch_output_valid(exec_branch_output_valid),
        .exec_branch_exception(exec_branch_exception),
        .exec_branch_taken(exec_branch_taken), .exec_branch_result(exec_branch_result),
        .exec_branch_target(), .last_branch_target(redirect_addr),
        .exec_mispredict_detected(exec_mispredict_detected)
    );

    exec_alu #(.XLEN(XLEN), .ALEN(ALEN)) alu0 (
        .clk(clk), .rst(rst), .d_addr(d_addr), .opcode(d_opcode), .funct3(d_funct3),
        .funct7_5(d_funct7_5), .rs1_data(rs1_data), .rs2_data(rs2_data), .i_imm(i_imm),
        .u_imm(u_imm), .input_valid(input_valid), .input_is_branch(input_is_branch),
        .alu_output_valid(alu_output_valid), .alu_exception(alu_exception),
        .alu_result(alu_result)
    );

    exec_writeback #(.XLEN(XLEN)) wb0 (
        .clk(clk), .rst(rst), .exec_branch_output_valid(exec_branch_output_valid),
        .exec_branch_exception(exec_branch_exception),
        .exec_branch_taken(exec_branch_taken), .exec_branch_result(exec_branch_result),
        .alu_output_valid(alu_output_valid), .alu_exception(alu_exception),
        .alu_result(alu_result), .d_rd(d_rd), .retire_valid(retire_valid),
        .retire_rd(retire_rd), .retire_data(retire_data),
        .retire_exception(retire_exception), .retire_taken(retire_taken), .we(we),
        .wr_rd(wr_rd), .wr_data(wr_data)
    );

endmodule

`default_nettype wire

// ==== hdl/exec_writeback.sv ====
`default_nettype none

module exec_writeback #(
    parameter int XLEN = 32
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              exec_branch_output_valid,
    input  wire              exec_branch_exception,
    input  wire              exec_branch_taken,
    input  wire  [XLEN-1:0]  exec_branch_result,
    input  wire              alu_output_valid,
    input  wire              alu_exception,
    input  wire  [XLEN-1:0]  alu_result,
    input  wire  [4:0]       d_rd,
    output logic             retire_valid,
    output logic [4:0]       retire_rd,
    output logic [XLEN-1:0]  retire_data,
    output logic             retire_exception,
    output logic             retire_taken,
    output logic             we,
    output logic [4:0]       wr_rd,
    output logic [XLEN-1:0]  wr_data
);

    logic [4:0] rd_q;

    // rd trails decode by one cycle, in step with the execute registers
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_q <= 5'd0;
        end else begin
            rd_q <= d_rd;
        end
    end

    assign retire_valid     = exec_branch_output_valid || alu_output_valid;
    assign retire_rd        = rd_q;
    assign retire_data      = exec_branch_output_valid ? exec_branch_result : alu_result;
    assign retire_exception = (exec_branch_output_valid && exec_branch_exception) ||
                              (alu_output_valid && alu_exception);
    assign retire_taken     = exec_branch_output_valid && exec_branch_taken;

    assign we      = retire_valid && !retire_exception && (rd_q != 5'd0);
    assign wr_rd   = rd_q;
    assign wr_data = retire_data;

endmodule

`default_nettype wire

// ==== hdl/instr_decode.sv ====
`default_nettype none

module instr_decode #(
    parameter int XLEN = 32,
    parameter int ALEN = 32
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                in_valid,
    input  wire  [31:0]        in_instr,
    input  wire  [ALEN-1:0]    in_addr,
    input  wire                flush,
    output logic               d_valid,
    output logic [ALEN-1:0]    d_addr,
    output logic [ALEN-1:0]    d_next_addr,
    output core_pkg::opcode_e  d_opcode,
    output logic [4:0]         d_rd,
    output logic [2:0]         d_funct3,
    output logic               d_funct7_5,
    output logic [4:0]         d_rs1,
    output logic [4:0]         d_rs2,
    output logic [XLEN-1:0]    i_imm,
    output logic [XLEN-1:0]    b_imm,
    output logic [XLEN-1:0]    j_imm,
    output logic [XLEN-1:0]    u_imm
);

    logic [31:0] instr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= in_valid && !flush; // Wrong-path word dropped
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            instr_q <= in_instr;
            d_addr  <= in_addr;
        end
    end

    assign d_next_addr = d_addr + ALEN'(4); // No compressed instructions

    assign d_opcode   = core_pkg::opcode_e'(instr_q[6:2]);
    assign d_funct3   = instr_q[14:12];
    assign d_funct7_5 = instr_q[30];
    assign d_rs1      = instr_q[19:15];
    assign d_rs2      = instr_q[24:20];

    // Conditional branches carry immediate bits in the rd slot
    assign d_rd = (d_opcode == core_pkg::OP_BRANCH) ? 5'd0 : instr_q[11:7];

    assign i_imm = XLEN'($signed(instr_q[31:20]));
    assign b_imm = XLEN'($signed({instr_q[31], instr_q[7], instr_q[30:25],
                                  instr_q[11:8], 1'b0}));
    assign j_imm = XLEN'($signed({instr_q[31], instr_q[19:12], instr_q[20],
                                  instr_q[30:21], 1'b0}));
    assign u_imm = XLEN'($signed({instr_q[31:12], 12'b0}));

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`default_nettype none

module reg_file #(
    parameter int XLEN = 32
) (
    input  wire              clk,
    input  wire              rst,
    input  wire  [4:0]       rs1,
    input  wire  [4:0]       rs2,
    input  wire              we,
    input  wire  [4:0]       wr_rd,
    input  wire  [XLEN-1:0]  wr_data,
    output logic [XLEN-1:0]  rs1_data,
    output logic [XLEN-1:0]  rs2_data
);

    logic [XLEN-1:0] regs [31:1];
    logic            wr_active;

    assign wr_active = we && !rst && (wr_rd != 5'd0);

    always_ff @(posedge clk) begin
        if (wr_active) begin
            regs[wr_rd] <= wr_data;
        end
    end

    // Write-through covers the instruction right behind the writer
    always_comb begin
        if (rs1 == 5'd0) begin
            rs1_data = '0;
        end else if (wr_active && wr_rd == rs1) begin
            rs1_data = wr_data;
        end else begin
            rs1_data = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == 5'd0) begin
            rs2_data = '0;
        end else if (wr_active && wr_rd == rs2) begin
            rs2_data = wr_data;
        end else begin
            rs2_data = regs[rs2];
        end
    end

endmodule

`default_nettype wire

// ==== tests/exec_stage_checker.sv ====
`default_nettype none

module exec_stage_checker (
    input wire clk,
    input wire rst,
    input wire retire_valid,
    input wire retire_exception,
    input wire retire_taken,
    input wire redirect_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    int   assert_fails = 0;
    logic rst_q;
    logic taken_seen; // Most recent retire was taken and not yet redirected

    always_ff @(posedge clk) begin
        rst_q <= rst;
        if (rst || redirect_valid) begin
            taken_seen <= 1'b0;
        end else if (retire_valid) begin
            taken_seen <= retire_taken;
        end
    end

    exc_needs_valid: assert property (@(posedge clk) disable iff (rst)
        retire_exception |-> retire_valid)
        else begin $error("retire_exception without retire_valid"); assert_fails++; end

    single_redirect: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |=> !redirect_valid)
        else begin $error("redirect_valid high two cycles in a row"); assert_fails++; end

    redirect_after_taken: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |-> (taken_seen || (retire_valid && retire_taken)))
        else begin $error("redirect_valid without a taken retire"); assert_fails++; end

    quiet_in_reset: assert property (@(posedge clk) (rst && rst_q) |->
        !(retire_valid || retire_exception || retire_taken || redirect_valid))
        else begin $error("control output active during reset"); assert_fails++; end

endmodule

bind exec_stage exec_stage_checker checker0 (
    .clk(clk), .rst(rst), .retire_valid(retire_valid),
    .retire_exception(retire_exception), .retire_taken(retire_taken),
    .redirect_valid(redirect_valid)
);

`default_nettype wire

// ==== tests/exec_stage_tb.sv ====
`default_nettype none

module exec_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int K_REG = 0, K_IMM = 1, K_AUIPC = 2, K_BR = 3, K_JAL = 4, K_JALR = 5;

    typedef struct {
        int          kind;
        logic [2:0]  f3;
        logic        sub;
        logic [31:0] v1;
        logic [31:0] v2;
        int          imm;
        logic        rnd;
        logic        taken;
        logic        exc;
        int          gap;
    } row_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_instr;
    logic [31:0] in_addr;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        retire_exception;
    logic        retire_taken;
    logic        redirect_valid;
    logic [31:0] redirect_addr;

    row_t        rows[$];
    logic [31:0] exp_data[$];
    logic [7:0]  exp_info[$];
    logic [31:0] got_data[$];
    logic [6:0]  got_info[$];
    int          redirect_count;
    logic        table_ready = 1'b0;
    integer      seed = 24;
    logic [31:0] x3_model;
    logic [31:0] x5_model;

    exec_stage #(.XLEN(32), .ALEN(32)) dut0 (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_instr(in_instr), .in_addr(in_addr),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data),
        .retire_exception(retire_exception), .retire_taken(retire_taken),
        .redirect_valid(redirect_valid), .redirect_addr(redirect_addr)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (retire_valid) begin
                got_data.push_back(retire_data);
                got_info.push_back({retire_rd, retire_exception, retire_taken});
            end
            if (redirect_valid) begin
                redirect_count++;
            end
        end
    end

    always @(negedge clk) begin
        if (dut0.checker0.assert_fails != 0) begin
            $display("An assertion in the bound checker failed");
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    initial begin
        wait (table_ready);
        repeat (rows.size() * 20 + 100) @(posedge clk);
        $display("Timeout: the DUT stopped retiring instructions");
        $display("ERRORS FOUND");
        $fatal(1);
    end

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] op);
        return {imm, rs1, f3, rd, op, 2'b11};
    endfunction

    function automatic logic [31:0] enc_r(input logic sub, input logic [2:0] f3);
        return {1'b0, sub, 5'b0, 5'd2, 5'd1, f3, 5'd5, 5'(core_pkg::OP_REG), 2'b11};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11],
                5'(core_pkg::OP_BRANCH), 2'b11};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd5, 5'(core_pkg::OP_JAL), 2'b11};
    endfunction

    function automatic logic [31:0] alu_expect(input logic [2:0] f3, input logic sub,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 32'b0;
        endcase
    endfunction

    task automatic add_row(input int kind, input logic [2:0] f3, input logic sub,
                           input logic [31:0] v1, input logic [31:0] v2, input int imm,
                           input logic rnd, input logic taken, input logic exc,
                           input int gap);
        rows.push_back('{kind, f3, sub, v1, v2, imm, rnd, taken, exc, gap});
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic issue(input logic [31:0] addr, input logic [31:0] word);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_addr  = addr;
        in_instr = word;
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic expect_retire(input logic [4:0] rd, input logic [31:0] data,
                                 input logic exc, input logic taken, input logic chk);
        exp_data.push_back(data);
        exp_info.push_back({rd, exc, taken, chk});
    endtask

    task automatic compare_retires();
        logic [7:0] e;
        logic [6:0] g;
        logic [31:0] d;
        while (got_data.size() < exp_data.size()) @(posedge clk);
        while (exp_data.size() > 0) begin
            e = exp_info.pop_front();
            g = got_info.pop_front();
            d = got_data.pop_front();
            check("retire_rd", 32'(g[6:2]), 32'(e[7:3]));
            if (e[0]) check("retire_data", d, exp_data[0]);
            void'(exp_data.pop_front());
            check("retire_exception", 32'(g[1]), 32'(e[2]));
            check("retire_taken", 32'(g[0]), 32'(e[1]));
        end
        check("extra retires", got_data.size(), 0);
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [31:0] v, input logic [31:0] a);
        logic [31:0] lo;
        lo = 32'($signed(v[11:0]));
        issue(a, {v[31:12] + 20'(v[11]), rd, 5'(core_pkg::OP_LUI), 2'b11});
        expect_retire(rd, v - lo, 0, 0, 1);
        issue(a + 4, enc_i(v[11:0], rd, 3'b000, rd, core_pkg::OP_IMM)); // Needs write-through
        expect_retire(rd, v, 0, 0, 1);
    endtask

    initial begin
        row_t        r;
        logic [31:0] base, word, data, target, taken_addr;
        logic [4:0]  rd;
        logic        exp_redirect, redirected;
        rst = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        in_addr = '0;
        redirect_count = 0;
        // kind, funct3, sub, rs1, rs2, imm, random, taken, exception, gap
        add_row(K_REG, 0, 0, 100, 23, 0, 0, 0, 0, 0);
        add_row(K_REG, 0, 1, 5, 9, 0, 0, 0, 0, 0);
        add_row(K_REG, 2, 0, -4, 3, 0, 0, 0, 0, 0);
        add_row(K_REG, 3, 0, -4, 3, 0, 0, 0, 0, 0);
        add_row(K_REG, 4, 0, 32'hf0f0_1234, 32'h0ff0_4321, 0, 0, 0, 0, 0);
        add_row(K_REG, 6, 0, 32'hf0f0_1234, 32'h0ff0_4321, 0, 0, 0, 0, 0);
        add_row(K_REG, 7, 0, 32'hf0f0_1234, 32'h0ff0_4321, 0, 0, 0, 0, 0);
        add_row(K_IMM, 0, 0, 40, 0, -7, 0, 0, 0, 0);
        add_row(K_IMM, 2, 0, -9, 0, 5, 0, 0, 0, 0);
        add_row(K_IMM, 4, 0, 32'h1234_5678, 0, -1, 0, 0, 0, 0);
        add_row(K_AUIPC, 0, 0, 0, 0, 32'h12345, 0, 0, 0, 0);
        add_row(K_REG, 1, 0, 3, 4, 0, 0, 0, 1, 0); // SLL
        add_row(K_REG, 0, 0, 0, 0, 0, 1, 0, 0, 0);
        add_row(K_REG, 0, 1, 0, 0, 0, 1, 0, 0, 0);
        add_row(K_REG, 2, 0, 0, 0, 0, 1, 0, 0, 0);
        add_row(K_REG, 3, 0, 0, 0, 0, 1, 0, 0, 0);
        add_row(K_BR, 0, 0, 7, 7, 64, 0, 1, 0, 0);
        add_row(K_BR, 0, 0, 7, 8, 64, 0, 0, 0, 0);
        add_row(K_BR, 1, 0, 7, 8, -32, 0, 1, 0, 4);
        add_row(K_BR, 4, 0, -5, 3, 96, 0, 1, 0, 0);
        add_row(K_BR, 5, 0, -5, 3, 96, 0, 0, 0, 0);
        add_row(K_BR, 6, 0, -5, 3, 96, 0, 0, 0, 0);
        add_row(K_BR, 7, 0, -5, 3, 96, 0, 1, 0, 3);
        add_row(K_BR, 4, 0, 3, -5, 64, 0, 0, 0, 0);
        add_row(K_BR, 6, 0, 3, -5, 64, 0, 1, 0, 0);
        add_row(K_BR, 1, 0, 9, 9, 64, 0, 0, 0, 0);
        add_row(K_BR, 4, 0, 9, 9, 64, 0, 0, 0, 0);
        add_row(K_BR, 5, 0, 9, 9, 64, 0, 1, 0, 0);
        add_row(K_BR, 6, 0, 9, 9, 64, 0, 0, 0, 0);
        add_row(K_BR, 7, 0, 9, 9, 64, 0, 1, 0, 0);
        add_row(K_BR, 0, 0, 9, 9, 4, 0, 1, 0, 0);
        add_row(K_BR, 2, 0, 9, 9, 64, 0, 0, 1, 0);
        add_row(K_BR, 3, 0, 9, 9, 64, 0, 0, 1, 0);
        add_row(K_BR, 0, 0, 9, 9, 6, 0, 1, 1, 0);
        add_row(K_JAL, 0, 0, 0, 0, 128, 0, 1, 0, 0);
        add_row(K_JAL, 0, 0, 0, 0, 2, 0, 1, 1, 0);
        add_row(K_JALR, 0, 0, 32'h2001, 0, 32'h20, 0, 1, 0, 0);
        add_row(K_JALR, 1, 0, 32'h2000, 0, 0, 0, 1, 1, 0);
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        issue(32'h100, enc_i(0, 0, 3'b000, 3, core_pkg::OP_IMM));
        expect_retire(3, 0, 0, 0, 1);
        issue(32'h104, enc_i(0, 0, 3'b000, 5, core_pkg::OP_IMM));
        expect_retire(5, 0, 0, 0, 1);
        x3_model = 0;
        x5_model = 0;
        idle();
        compare_retires();
        foreach (rows[i]) begin
            r = rows[i];
            if (r.rnd) begin
                r.v1 = $random(seed);
                r.v2 = $random(seed);
            end
            base = 32'h1000 + 32'(i) * 32'h100;
            redirect_count = 0;
            load_reg(1, r.v1, base);
            load_reg(2, r.v2, base + 8);
            base = base + 16; // Address of the instruction under test
            rd = 5;
            target = base + 32'(r.imm);
            data = base + 4; // Link value
            case (r.kind)
                K_REG: begin
                    word = enc_r(r.sub, r.f3);
                    data = alu_expect(r.f3, r.sub, r.v1, r.v2);
                end
                K_IMM: begin
                    word = enc_i(12'(r.imm), 1, r.f3, 5, core_pkg::OP_IMM);
                    data = alu_expect(r.f3, 0, r.v1, 32'(r.imm));
                end
                K_AUIPC: begin
                    word = {20'(r.imm), 5'd5, 5'(core_pkg::OP_AUIPC), 2'b11};
                    data = base + (32'(r.imm) << 12);
                end
                K_BR: begin
                    word = enc_b(13'(r.imm), r.f3);
                    rd = 0;
                end
                K_JAL: word = enc_j(21'(r.imm));
                default: begin
                    word = enc_i(12'(r.imm), 1, r.f3, 5, core_pkg::OP_JALR);
                    target = (r.v1 + 32'(r.imm)) & ~32'd1;
                end
            endcase
            exp_redirect = r.taken && (target != base + 4);
            issue(base, word);
            expect_retire(rd, data, r.exc, r.taken, !r.exc);
            if (!r.exc && rd != 0) x5_model = data;
            repeat (r.gap) idle();
            issue(base + 4, enc_i(12'(i + 1), 0, 3'b000, 3, core_pkg::OP_IMM));
            idle();
            redirected = redirect_valid; // Fall-through ADDI now in decode
            taken_addr = redirect_addr;
            check("redirect_valid", 32'(redirected), 32'(exp_redirect));
            if (redirected) begin
                check("redirect_addr", taken_addr, target);
            end else begin
                expect_retire(3, i + 1, 0, 0, 1);
                x3_model = i + 1;
            end
            issue(redirected ? taken_addr : base + 8,
                  {7'b0, 5'd5, 5'd3, 3'b000, 5'd4, 5'(core_pkg::OP_REG), 2'b11});
            expect_retire(4, x3_model + x5_model, 0, 0, 1);
            idle();
            compare_retires();
            check("redirect_count", redirect_count, 32'(exp_redirect));
        end
        repeat (4) @(posedge clk);
        if (dut0.checker0.assert_fails == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("An assertion in the bound checker failed");
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
